// File: hw/hyper_pkg.sv
// Shared widths, types and constants of the HyperBus PHY
// One 16-bit bus word moves per clk0 cycle, the bus runs without DDR
// Latency and recovery counts are in clk0 cycles, minimum value 2
// Burst length counts 16-bit words and must not be zero
`default_nettype none

package hyper_pkg;

    localparam int WORD_W   = 16;
    localparam int STRB_W   = 2;
    localparam int ADDR_W   = 32;
    localparam int BURST_W  = 12;
    localparam int LAT_W    = 4;
    localparam int NR_CS    = 2;
    localparam int CA_W     = 48;
    localparam int CA_SEL_W = 2;

    // Command/address layout
    localparam int CA_READ_BIT  = 47;
    localparam int CA_SPACE_BIT = 46;
    localparam int CA_BURST_BIT = 45;
    localparam int CA_WORDS     = 3;    // Word 0 holds bits 47..32

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [STRB_W-1:0]   strb_t;   // Bit 1 is the upper byte
    typedef logic [ADDR_W-1:0]   addr_t;   // Word address
    typedef logic [BURST_W-1:0]  burst_t;
    typedef logic [LAT_W-1:0]    lat_t;
    typedef logic [NR_CS-1:0]    cs_t;
    typedef logic [CA_W-1:0]     ca_t;
    typedef logic [CA_SEL_W-1:0] ca_sel_t;

    localparam lat_t WAIT_CNT_RST = 4'd6; // Wait counter out of reset

    typedef enum logic [3:0] {
        STANDBY,
        SET_CA,
        CMD_ADDR,
        REG_WRITE,
        WAIT2,      // Doubled latency requested by the memory
        WAIT,
        DATA_W,
        WAIT_W,
        DATA_R,
        WAIT_R,
        END
    } trans_state_t;

endpackage

`default_nettype wire

// File: hw/hyper_ctrl_if.sv
// Control between the transaction FSM and the datapath blocks
// load_trans is a one-cycle pulse, cap_en and flush are levels
// is_write, is_reg_write and burst_len come from the captured transaction
`default_nettype none

interface hyper_ctrl_if;

    logic                load_trans;
    hyper_pkg::ca_sel_t  ca_sel;
    logic                cap_en;
    logic                flush;
    logic                is_write;
    logic                is_reg_write;
    hyper_pkg::burst_t   burst_len;

    modport fsm (
        output load_trans, ca_sel, cap_en, flush,
        input  is_write, is_reg_write, burst_len
    );

    modport ca (
        input  load_trans, ca_sel,
        output is_write, is_reg_write, burst_len
    );

    modport rd (input cap_en, flush);

endinterface

`default_nettype wire

// File: hw/hyper_cmd_addr.sv
// Holds the current transaction and serves its command/address words
// Transaction inputs are taken on the load_trans pulse only
// ca_sel values beyond the last word return zero
`default_nettype none

module hyper_cmd_addr (
    input  logic                 clk0,
    input  logic                 rst_ni,
    hyper_ctrl_if.ca             ctrl,
    input  hyper_pkg::addr_t     trans_address_i,
    input  hyper_pkg::cs_t       trans_cs_i,
    input  logic                 trans_write_i,
    input  hyper_pkg::burst_t    trans_burst_i,
    input  logic                 trans_burst_type_i,
    input  logic                 trans_address_space_i,
    output hyper_pkg::word_t     ca_word_o,
    output hyper_pkg::cs_t       cs_o
);

    hyper_pkg::addr_t  addr_q;
    hyper_pkg::burst_t burst_q;
    logic              write_q;
    logic              space_q;
    logic              burst_type_q;
    hyper_pkg::ca_t    ca;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            cs_o         <= '0;
            write_q      <= 1'b0;
            space_q      <= 1'b0;
            burst_type_q <= 1'b1;   // Linear burst
        end else if (ctrl.load_trans) begin
            cs_o         <= trans_cs_i;
            write_q      <= trans_write_i;
            space_q      <= trans_address_space_i;
            burst_type_q <= trans_burst_type_i;
        end
    end

    always_ff @(posedge clk0) begin
        if (ctrl.load_trans) begin
            addr_q  <= trans_address_i;
            burst_q <= trans_burst_i;
        end
    end

    always_comb begin
        ca = '0;
        ca[hyper_pkg::CA_READ_BIT]  = ~write_q;
        ca[hyper_pkg::CA_SPACE_BIT] = space_q;
        ca[hyper_pkg::CA_BURST_BIT] = burst_type_q;
        ca[44:16] = addr_q[31:3];  // Row and upper column
        ca[2:0]   = addr_q[2:0];   // Lower column, bits 15..3 reserved
    end

    always_comb begin
        case (ctrl.ca_sel)
            2'd0:    ca_word_o = ca[47:32];
            2'd1:    ca_word_o = ca[31:16];
            2'd2:    ca_word_o = ca[15:0];
            default: ca_word_o = '0;
        endcase
    end

    assign ctrl.is_write     = write_q;
    assign ctrl.is_reg_write = write_q && space_q;
    assign ctrl.burst_len    = burst_q;

endmodule

`default_nettype wire

// File: hw/hyper_trans_fsm.sv
// Transaction sequencing for one HyperBus access at a time
// cfg_latency_i and cfg_recovery_i are at least 2 and stable per transaction
// RWDS high in the last command/address cycle doubles the latency
// Read length counts rx handshakes, write length counts tx words
// ck_en drops on write underflow and on read back-pressure
`default_nettype none

module hyper_trans_fsm (
    input  logic                 clk0,
    input  logic                 rst_ni,
    hyper_ctrl_if.fsm            ctrl,
    input  logic                 trans_valid_i,
    output logic                 trans_ready_o,
    input  logic                 tx_valid_i,
    output logic                 tx_ready_o,
    input  logic                 rx_valid_i,
    input  logic                 rx_ready_i,
    output logic                 rx_last_o,
    output logic                 write_last_o,
    input  hyper_pkg::lat_t      cfg_latency_i,
    input  hyper_pkg::lat_t      cfg_recovery_i,
    input  logic                 hyper_rwds_i,
    output logic                 cs_en_o,
    output logic                 ck_en_o,
    output logic                 dq_oe_o,
    output logic                 rwds_oe_o,
    output logic                 mode_write_o
);

    hyper_pkg::trans_state_t state_q;
    hyper_pkg::lat_t         wait_cnt_q;
    hyper_pkg::burst_t       burst_cnt_q;
    hyper_pkg::ca_sel_t      ca_sel_q;
    logic                    ca_last;
    logic                    wait_done;
    logic                    burst_done;
    logic                    rx_hs;

    assign ca_last     = ca_sel_q == hyper_pkg::ca_sel_t'(hyper_pkg::CA_WORDS - 1);
    assign wait_done   = wait_cnt_q == '0;
    assign burst_done  = burst_cnt_q == '0;
    assign rx_hs       = rx_valid_i && rx_ready_i;
    assign ctrl.ca_sel = ca_sel_q;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= hyper_pkg::STANDBY;
            wait_cnt_q  <= hyper_pkg::WAIT_CNT_RST;
            burst_cnt_q <= '0;
            ca_sel_q    <= '0;
        end else begin
            case (state_q)
                hyper_pkg::STANDBY: begin
                    if (trans_valid_i) state_q <= hyper_pkg::SET_CA;
                end
                hyper_pkg::SET_CA: begin
                    ca_sel_q <= '0;
                    state_q  <= hyper_pkg::CMD_ADDR;
                end
                hyper_pkg::CMD_ADDR: begin
                    if (ca_last) begin
                        wait_cnt_q <= cfg_latency_i - hyper_pkg::lat_t'(1);
                        if (ctrl.is_reg_write) begin
                            state_q <= hyper_pkg::REG_WRITE;  // No latency
                        end else if (hyper_rwds_i) begin
                            state_q <= hyper_pkg::WAIT2;
                        end else begin
                            state_q <= hyper_pkg::WAIT;
                        end
                    end else begin
                        ca_sel_q <= ca_sel_q + hyper_pkg::ca_sel_t'(1);
                    end
                end
                hyper_pkg::REG_WRITE: begin
                    if (tx_valid_i) begin
                        wait_cnt_q <= cfg_recovery_i - hyper_pkg::lat_t'(1);
                        state_q    <= hyper_pkg::END;
                    end
                end
                hyper_pkg::WAIT2: begin
                    if (wait_done) begin
                        wait_cnt_q <= cfg_latency_i - hyper_pkg::lat_t'(1);
                        state_q    <= hyper_pkg::WAIT;
                    end else begin
                        wait_cnt_q <= wait_cnt_q - hyper_pkg::lat_t'(1);
                    end
                end
                hyper_pkg::WAIT: begin
                    if (wait_done) begin
                        burst_cnt_q <= ctrl.burst_len - hyper_pkg::burst_t'(1);
                        state_q     <= ctrl.is_write ? hyper_pkg::DATA_W : hyper_pkg::DATA_R;
                    end else begin
                        wait_cnt_q <= wait_cnt_q - hyper_pkg::lat_t'(1);
                    end
                end
                hyper_pkg::DATA_W: begin
                    if (!tx_valid_i) begin
                        state_q <= hyper_pkg::WAIT_W;      // Underflow
                    end else if (burst_done) begin
                        wait_cnt_q <= cfg_recovery_i - hyper_pkg::lat_t'(1);
                        state_q    <= hyper_pkg::END;
                    end else begin
                        burst_cnt_q <= burst_cnt_q - hyper_pkg::burst_t'(1);
                    end
                end
                hyper_pkg::WAIT_W: begin
                    if (tx_valid_i) state_q <= hyper_pkg::DATA_W;
                end
                hyper_pkg::DATA_R, hyper_pkg::WAIT_R: begin
                    if (rx_hs && burst_done) begin
                        wait_cnt_q <= cfg_recovery_i - hyper_pkg::lat_t'(1);
                        state_q    <= hyper_pkg::END;
                    end else begin
                        if (rx_hs) burst_cnt_q <= burst_cnt_q - hyper_pkg::burst_t'(1);
                        state_q <= rx_ready_i ? hyper_pkg::DATA_R : hyper_pkg::WAIT_R;
                    end
                end
                hyper_pkg::END: begin
                    if (wait_done) begin
                        state_q <= hyper_pkg::STANDBY;
                    end else begin
                        wait_cnt_q <= wait_cnt_q - hyper_pkg::lat_t'(1);
                    end
                end
                default: state_q <= hyper_pkg::STANDBY;
            endcase
        end
    end

    always_comb begin
        trans_ready_o   = 1'b0;
        ctrl.load_trans = 1'b0;
        ctrl.cap_en     = 1'b0;
        ctrl.flush      = 1'b0;
        tx_ready_o      = 1'b0;
        rx_last_o       = 1'b0;
        write_last_o    = 1'b0;
        cs_en_o         = 1'b0;
        ck_en_o         = 1'b0;
        dq_oe_o         = 1'b0;
        rwds_oe_o       = 1'b0;
        mode_write_o    = 1'b0;
        case (state_q)
            hyper_pkg::SET_CA: begin
                trans_ready_o   = 1'b1;
                ctrl.load_trans = 1'b1;
            end
            hyper_pkg::CMD_ADDR: begin
                cs_en_o = 1'b1;
                ck_en_o = 1'b1;
                dq_oe_o = 1'b1;
            end
            hyper_pkg::REG_WRITE: begin
                cs_en_o      = 1'b1;
                ck_en_o      = tx_valid_i;
                dq_oe_o      = 1'b1;
                tx_ready_o   = 1'b1;
                mode_write_o = 1'b1;
            end
            hyper_pkg::WAIT2, hyper_pkg::WAIT: begin
                cs_en_o = 1'b1;
                ck_en_o = 1'b1;
            end
            hyper_pkg::DATA_W: begin
                cs_en_o      = 1'b1;
                ck_en_o      = tx_valid_i;  // Clock only with a word on the bus
                dq_oe_o      = 1'b1;
                rwds_oe_o    = 1'b1;
                tx_ready_o   = 1'b1;
                mode_write_o = 1'b1;
                write_last_o = tx_valid_i && burst_done;
            end
            hyper_pkg::WAIT_W: begin
                cs_en_o      = 1'b1;
                dq_oe_o      = 1'b1;
                rwds_oe_o    = 1'b1;
                mode_write_o = 1'b1;
            end
            hyper_pkg::DATA_R: begin
                cs_en_o     = 1'b1;
                ck_en_o     = rx_ready_i;   // Memory stalls with rx
                ctrl.cap_en = 1'b1;
                rx_last_o   = rx_valid_i && burst_done;
            end
            hyper_pkg::WAIT_R: begin
                cs_en_o     = 1'b1;
                ctrl.cap_en = 1'b1;
                rx_last_o   = rx_valid_i && burst_done;
            end
            hyper_pkg::END: ctrl.flush = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/hyper_read_capture.sv
// Read word capture on the clk0 domain
// A word is valid on a cycle with hyper_rwds_i high while capture is on
// Two entries cover the word in flight after ck_en drops
// Words arriving into a full buffer are overrun words and are dropped
`default_nettype none

module hyper_read_capture (
    input  logic                 clk0,
    input  logic                 rst_ni,
    hyper_ctrl_if.rd             ctrl,
    input  hyper_pkg::word_t     hyper_dq_i,
    input  logic                 hyper_rwds_i,
    input  logic                 rx_ready_i,
    output logic                 rx_valid_o,
    output hyper_pkg::word_t     rx_data_o
);

    hyper_pkg::word_t buf_q [2];
    logic             wr_ptr_q;
    logic             rd_ptr_q;
    logic [1:0]       count_q;
    logic             push;
    logic             pop;

    assign rx_valid_o = (count_q != 2'd0) && !ctrl.flush;
    assign rx_data_o  = buf_q[rd_ptr_q];
    assign pop        = rx_valid_o && rx_ready_i;
    assign push       = ctrl.cap_en && hyper_rwds_i && ((count_q != 2'd2) || pop);

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else if (ctrl.flush) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) wr_ptr_q <= ~wr_ptr_q;
            if (pop)  rd_ptr_q <= ~rd_ptr_q;
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk0) begin
        if (push) buf_q[wr_ptr_q] <= hyper_dq_i;
    end

endmodule

`default_nettype wire

// File: hw/hyper_phy_top.sv
// HyperBus PHY top, single clk0 domain, one 16-bit word per cycle
// hyper_ck_en_o marks the cycles where the memory clock runs
// hyper_rwds_o carries one mask bit per byte, high masks the byte
// Transaction inputs must stay stable while trans_valid_i is high
`default_nettype none

module hyper_phy_top (
    input  logic                 clk0,
    input  logic                 rst_ni,
    input  hyper_pkg::lat_t      cfg_latency_i,
    input  hyper_pkg::lat_t      cfg_recovery_i,
    input  logic                 trans_valid_i,
    output logic                 trans_ready_o,
    input  hyper_pkg::addr_t     trans_address_i,
    input  hyper_pkg::cs_t       trans_cs_i,
    input  logic                 trans_write_i,
    input  hyper_pkg::burst_t    trans_burst_i,
    input  logic                 trans_burst_type_i,
    input  logic                 trans_address_space_i,
    input  logic                 tx_valid_i,
    output logic                 tx_ready_o,
    input  hyper_pkg::word_t     tx_data_i,
    input  hyper_pkg::strb_t     tx_strb_i,
    output logic                 rx_valid_o,
    input  logic                 rx_ready_i,
    output hyper_pkg::word_t     rx_data_o,
    output logic                 rx_last_o,
    output logic                 write_last_o,
    output hyper_pkg::cs_t       hyper_cs_no,
    output logic                 hyper_ck_en_o,
    output hyper_pkg::word_t     hyper_dq_o,
    output logic                 hyper_dq_oe_o,
    input  hyper_pkg::word_t     hyper_dq_i,
    output hyper_pkg::strb_t     hyper_rwds_o,
    output logic                 hyper_rwds_oe_o,
    input  logic                 hyper_rwds_i
);

    hyper_ctrl_if     ctrl ();
    hyper_pkg::word_t ca_word;
    hyper_pkg::cs_t   cs_sel;
    logic             cs_en;
    logic             mode_write;

    hyper_cmd_addr u_cmd_addr (
        .clk0                  (clk0),
        .rst_ni                (rst_ni),
        .ctrl                  (ctrl.ca),
        .trans_address_i       (trans_address_i),
        .trans_cs_i            (trans_cs_i),
        .trans_write_i         (trans_write_i),
        .trans_burst_i         (trans_burst_i),
        .trans_burst_type_i    (trans_burst_type_i),
        .trans_address_space_i (trans_address_space_i),
        .ca_word_o             (ca_word),
        .cs_o                  (cs_sel)
    );

    hyper_trans_fsm u_trans_fsm (
        .clk0           (clk0),
        .rst_ni         (rst_ni),
        .ctrl           (ctrl.fsm),
        .trans_valid_i  (trans_valid_i),
        .trans_ready_o  (trans_ready_o),
        .tx_valid_i     (tx_valid_i),
        .tx_ready_o     (tx_ready_o),
        .rx_valid_i     (rx_valid_o),
        .rx_ready_i     (rx_ready_i),
        .rx_last_o      (rx_last_o),
        .write_last_o   (write_last_o),
        .cfg_latency_i  (cfg_latency_i),
        .cfg_recovery_i (cfg_recovery_i),
        .hyper_rwds_i   (hyper_rwds_i),
        .cs_en_o        (cs_en),
        .ck_en_o        (hyper_ck_en_o),
        .dq_oe_o        (hyper_dq_oe_o),
        .rwds_oe_o      (hyper_rwds_oe_o),
        .mode_write_o   (mode_write)
    );

    hyper_read_capture u_read_capture (
        .clk0         (clk0),
        .rst_ni       (rst_ni),
        .ctrl         (ctrl.rd),
        .hyper_dq_i   (hyper_dq_i),
        .hyper_rwds_i (hyper_rwds_i),
        .rx_ready_i   (rx_ready_i),
        .rx_valid_o   (rx_valid_o),
        .rx_data_o    (rx_data_o)
    );

    assign hyper_dq_o   = mode_write ? tx_data_i : ca_word;
    assign hyper_rwds_o = mode_write ? ~tx_strb_i : '0;  // Low during latency
    assign hyper_cs_no  = ~(cs_sel & {hyper_pkg::NR_CS{cs_en}});

endmodule

`default_nettype wire

// File: test/hyper_mem_model.sv
// Behavioral HyperBus memory at the PHY pins, one word per clk0 cycle
// Only address bits 7..0 select a word, 256 words in all
// Read words come one cycle after each clocked cycle, marked by RWDS high
// dbl_lat_i holds RWDS high during the command phase to ask for doubled latency
`default_nettype none

module hyper_mem_model (
    input  logic                 clk0,
    input  logic                 rst_ni,
    input  hyper_pkg::lat_t      lat_i,
    input  logic                 dbl_lat_i,
    input  hyper_pkg::cs_t       hyper_cs_ni,
    input  logic                 hyper_ck_en_i,
    input  hyper_pkg::word_t     hyper_dq_i,
    input  hyper_pkg::strb_t     hyper_rwds_i,
    output hyper_pkg::word_t     hyper_dq_o,
    output logic                 hyper_rwds_o,
    output hyper_pkg::word_t     ca_o [3],
    output hyper_pkg::word_t     reg_o
);

    hyper_pkg::word_t mem [256];
    logic [1:0]       ca_cnt;
    logic [4:0]       lat_cnt;
    logic [7:0]       addr;
    logic             rd_valid;
    logic             sel;
    logic             clk_on;
    logic             data_cyc;
    logic             is_read;
    logic             is_reg;

    assign sel          = hyper_cs_ni != '1;
    assign clk_on       = sel && hyper_ck_en_i;
    assign data_cyc     = clk_on && (ca_cnt == 2'd3) && (lat_cnt == 5'd0);
    assign is_read      = ca_o[0][15];
    assign is_reg       = ca_o[0][14] && !ca_o[0][15];
    assign hyper_rwds_o = (sel && (ca_cnt != 2'd3) && dbl_lat_i) || rd_valid;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0] ^ 8'ha5, i[7:0]};  // Fill depends on the full address
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            ca_cnt   <= 2'd0;
            lat_cnt  <= 5'd0;
            addr     <= 8'd0;
            rd_valid <= 1'b0;
            reg_o    <= '0;
            ca_o     <= '{default: '0};
        end else begin
            rd_valid <= data_cyc && is_read;
            if (!sel) begin
                ca_cnt  <= 2'd0;
                lat_cnt <= 5'd0;
            end else if (clk_on) begin
                if (ca_cnt != 2'd3) begin
                    ca_o[ca_cnt] <= hyper_dq_i;
                    ca_cnt       <= ca_cnt + 2'd1;
                    if (ca_cnt == 2'd2) begin
                        addr    <= {ca_o[1][4:0], hyper_dq_i[2:0]};
                        lat_cnt <= is_reg ? 5'd0 : ({1'b0, lat_i} << dbl_lat_i);
                    end
                end else if (lat_cnt != 5'd0) begin
                    lat_cnt <= lat_cnt - 5'd1;
                end else if (is_reg) begin
                    reg_o <= hyper_dq_i;
                end else begin
                    addr <= addr + 8'd1;
                end
            end
        end
    end

    always @(posedge clk0) begin
        if (data_cyc && is_read) begin
            hyper_dq_o <= mem[addr];
        end else if (data_cyc && !is_reg) begin
            if (!hyper_rwds_i[0]) mem[addr][7:0]  <= hyper_dq_i[7:0];   // RWDS high masks
            if (!hyper_rwds_i[1]) mem[addr][15:8] <= hyper_dq_i[15:8];
        end
    end

endmodule

`default_nettype wire

// File: test/tb_hyper_phy.sv
// Testbench for the HyperBus PHY with a behavioral memory on the pins
// Memory words are addressed by address bits 7..0 only
// Latency 3 and recovery 2 for every transaction
`default_nettype none

module tb_hyper_phy;

    localparam int N_TRANS = 6;

    logic                 clk0;
    logic                 rst_ni;
    hyper_pkg::lat_t      cfg_latency;
    hyper_pkg::lat_t      cfg_recovery;
    logic                 trans_valid_i;
    logic                 trans_ready_o;
    hyper_pkg::addr_t     trans_address_i;
    hyper_pkg::cs_t       trans_cs_i;
    logic                 trans_write_i;
    hyper_pkg::burst_t    trans_burst_i;
    logic                 trans_burst_type_i;
    logic                 trans_address_space_i;
    logic                 tx_valid_i;
    logic                 tx_ready_o;
    hyper_pkg::word_t     tx_data_i;
    hyper_pkg::strb_t     tx_strb_i;
    logic                 rx_valid_o;
    logic                 rx_ready_i;
    hyper_pkg::word_t     rx_data_o;
    logic                 rx_last_o;
    logic                 write_last_o;
    hyper_pkg::cs_t       hyper_cs_no;
    logic                 hyper_ck_en_o;
    hyper_pkg::word_t     phy_dq;
    logic                 phy_dq_oe;
    hyper_pkg::word_t     mem_dq;
    hyper_pkg::strb_t     phy_rwds;
    logic                 phy_rwds_oe;
    logic                 mem_rwds;
    logic                 dbl_lat;
    hyper_pkg::word_t     ca_words [3];
    hyper_pkg::word_t     reg_val;

    logic [31:0] rng;
    logic [7:0]  exp_mem [512];   // Byte image of the memory
    int          err_cnt;
    int          chk_cnt;
    int          rd_len;
    int          rd_cnt;
    logic [7:0]  rd_base;

    hyper_phy_top dut_i (
        .clk0 (clk0), .rst_ni (rst_ni),
        .cfg_latency_i (cfg_latency), .cfg_recovery_i (cfg_recovery),
        .trans_valid_i (trans_valid_i), .trans_ready_o (trans_ready_o),
        .trans_address_i (trans_address_i), .trans_cs_i (trans_cs_i),
        .trans_write_i (trans_write_i), .trans_burst_i (trans_burst_i),
        .trans_burst_type_i (trans_burst_type_i),
        .trans_address_space_i (trans_address_space_i),
        .tx_valid_i (tx_valid_i), .tx_ready_o (tx_ready_o),
        .tx_data_i (tx_data_i), .tx_strb_i (tx_strb_i),
        .rx_valid_o (rx_valid_o), .rx_ready_i (rx_ready_i),
        .rx_data_o (rx_data_o), .rx_last_o (rx_last_o),
        .write_last_o (write_last_o),
        .hyper_cs_no (hyper_cs_no), .hyper_ck_en_o (hyper_ck_en_o),
        .hyper_dq_o (phy_dq), .hyper_dq_oe_o (phy_dq_oe), .hyper_dq_i (mem_dq),
        .hyper_rwds_o (phy_rwds), .hyper_rwds_oe_o (phy_rwds_oe),
        .hyper_rwds_i (mem_rwds)
    );

    hyper_mem_model mem_i (
        .clk0 (clk0), .rst_ni (rst_ni), .lat_i (cfg_latency), .dbl_lat_i (dbl_lat),
        .hyper_cs_ni (hyper_cs_no), .hyper_ck_en_i (hyper_ck_en_o),
        .hyper_dq_i (phy_dq), .hyper_rwds_i (phy_rwds),
        .hyper_dq_o (mem_dq), .hyper_rwds_o (mem_rwds),
        .ca_o (ca_words), .reg_o (reg_val)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected word from the byte image, upper byte at the odd index
    function automatic hyper_pkg::word_t mem_expect(input logic [7:0] a);
        return {exp_mem[{a, 1'b1}], exp_mem[{a, 1'b0}]};
    endfunction

    function automatic hyper_pkg::ca_t ca_expect(input hyper_pkg::addr_t a, input logic wr,
                                                 input logic sp, input logic bt);
        // Fields from bit 47 down to bit 0
        return {!wr, sp, bt, a[31:3], 13'd0, a[2:0]};
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        err_cnt++;
        $display("[FAIL] %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic send_trans(input hyper_pkg::addr_t a, input logic wr, input logic sp,
                              input logic bt, input int len);
        logic taken;
        @(posedge clk0);
        trans_address_i       <= a;
        trans_write_i         <= wr;
        trans_address_space_i <= sp;
        trans_burst_type_i    <= bt;
        trans_burst_i         <= hyper_pkg::burst_t'(len);
        trans_valid_i         <= 1'b1;
        do begin
            @(negedge clk0);
            taken = trans_ready_o;
            @(posedge clk0);
        end while (!taken);
        trans_valid_i <= 1'b0;
    endtask

    task automatic check_ca(input hyper_pkg::addr_t a, input logic wr, input logic sp,
                            input logic bt);
        hyper_pkg::ca_t exp;
        exp = ca_expect(a, wr, sp, bt);
        chk_cnt++;
        if ({ca_words[0], ca_words[1], ca_words[2]} !== exp)
            report_value("ca_words", 64'({ca_words[0], ca_words[1], ca_words[2]}), 64'(exp));
    endtask

    // Write burst, or a register write when sp is set
    task automatic write_burst(input hyper_pkg::addr_t a, input int len, input logic gaps,
                               input logic dbl, input logic sp);
        int               ck_cnt;
        int               exp_lat;
        logic             hs;
        logic             first;
        logic             exp_last;
        logic [7:0]       wa;
        hyper_pkg::word_t d;
        hyper_pkg::strb_t s;
        hyper_pkg::cs_t   exp_cs;
        dbl_lat <= dbl;
        exp_lat = sp ? 0 : (dbl ? 2 : 1) * int'(cfg_latency);
        exp_cs  = ~trans_cs_i;
        send_trans(a, 1'b1, sp, 1'b1, len);
        ck_cnt = 0;
        first  = 1'b1;
        for (int n = 0; n < len; n++) begin
            rng = xorshift(rng);
            d   = rng[15:0];
            s   = sp ? 2'b11 : rng[17:16];
            wa  = a[7:0] + n[7:0];
            tx_valid_i <= 1'b1;
            tx_data_i  <= d;
            tx_strb_i  <= s;
            do begin
                @(negedge clk0);
                hs = tx_valid_i && tx_ready_o;
                if (first && !hs && hyper_ck_en_o && hyper_cs_no != '1) ck_cnt++;
                if (hs) begin
                    if (first) begin
                        chk_cnt++;
                        if (ck_cnt - 3 != exp_lat)
                            report_value("latency cycles", 64'(ck_cnt - 3), 64'(exp_lat));
                        first = 1'b0;
                    end
                    exp_last = !sp && (n == len - 1);
                    chk_cnt += 4;
                    if (write_last_o !== exp_last)
                        report_value("write_last_o", 64'(write_last_o), 64'(exp_last));
                    if (phy_dq_oe !== 1'b1)
                        report_value("hyper_dq_oe_o", 64'(phy_dq_oe), 64'd1);
                    if (!sp && phy_rwds_oe !== 1'b1)
                        report_value("hyper_rwds_oe_o", 64'(phy_rwds_oe), 64'd1);
                    if (hyper_cs_no !== exp_cs)
                        report_value("hyper_cs_no", 64'(hyper_cs_no), 64'(exp_cs));
                    if (!sp && s[0]) exp_mem[{wa, 1'b0}] = d[7:0];
                    if (!sp && s[1]) exp_mem[{wa, 1'b1}] = d[15:8];
                end
                @(posedge clk0);
            end while (!hs);
            if (gaps && n < len - 1 && rng[20]) begin
                tx_valid_i <= 1'b0;   // Underflow gap
                @(negedge clk0);
                chk_cnt++;
                if (hyper_ck_en_o !== 1'b0)
                    report_value("hyper_ck_en_o", 64'(hyper_ck_en_o), 64'd0);
                @(posedge clk0);
            end
        end
        tx_valid_i <= 1'b0;
        @(negedge clk0);
        if (sp) begin
            chk_cnt++;
            if (reg_val !== d) report_value("reg_val", 64'(reg_val), 64'(d));
        end
        @(posedge clk0);
        check_ca(a, 1'b1, sp, 1'b1);
    endtask

    task automatic read_burst(input hyper_pkg::addr_t a, input int len, input logic bp,
                              input logic dbl, input logic bt);
        dbl_lat <= dbl;
        rd_base = a[7:0];
        rd_len  = len;
        rd_cnt  = 0;
        send_trans(a, 1'b0, 1'b0, bt, len);
        while (rd_cnt < rd_len) begin
            rng = xorshift(rng);
            rx_ready_i <= (bp && rd_cnt > 0) ? (rng[1:0] != 2'b00) : 1'b1;
            @(posedge clk0);
        end
        rx_ready_i <= 1'b1;
        check_ca(a, 1'b0, 1'b0, bt);
    endtask

    // Compare process for every rx handshake
    always @(negedge clk0) begin
        if (rd_cnt > 0 && rd_cnt < rd_len && !rx_ready_i) begin
            chk_cnt++;
            if (hyper_ck_en_o !== 1'b0) report_value("hyper_ck_en_o", 64'(hyper_ck_en_o), 64'd0);
        end
        if (rst_ni && rx_valid_o && rx_ready_i) begin
            if (rd_cnt >= rd_len) begin
                err_cnt++;
                $display("[FAIL] %0t: rx word arrived with no read pending", $time);
            end else begin
                chk_cnt += 4;
                if (rx_data_o !== mem_expect(rd_base + rd_cnt[7:0]))
                    report_value("rx_data_o", 64'(rx_data_o),
                                 64'(mem_expect(rd_base + rd_cnt[7:0])));
                if (rx_last_o !== (rd_cnt == rd_len - 1))
                    report_value("rx_last_o", 64'(rx_last_o), 64'(rd_cnt == rd_len - 1));
                if (phy_dq_oe !== 1'b0) report_value("hyper_dq_oe_o", 64'(phy_dq_oe), 64'd0);
                if (phy_rwds_oe !== 1'b0)
                    report_value("hyper_rwds_oe_o", 64'(phy_rwds_oe), 64'd0);
                rd_cnt++;
            end
        end
    end

    initial begin
        clk0 = 1'b0;
        forever #10 clk0 = ~clk0;
    end

    initial begin
        #(N_TRANS * 200 * 20);
        $display("Watchdog timeout: the DUT stopped responding");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_ni <= 1'b0;
        cfg_latency <= 4'd3;
        cfg_recovery <= 4'd2;
        trans_valid_i <= 1'b0;
        trans_address_i <= '0;
        trans_cs_i <= 2'b01;
        trans_write_i <= 1'b0;
        trans_burst_i <= '0;
        trans_burst_type_i <= 1'b1;
        trans_address_space_i <= 1'b0;
        tx_valid_i <= 1'b0;
        tx_data_i <= '0;
        tx_strb_i <= '0;
        rx_ready_i <= 1'b1;
        dbl_lat <= 1'b0;
        rng = 32'd37;
        err_cnt = 0;
        chk_cnt = 0;
        rd_len = 0;
        rd_cnt = 0;
        rd_base = '0;
        for (int i = 0; i < 256; i++) begin
            exp_mem[2 * i]     = i[7:0];
            exp_mem[2 * i + 1] = i[7:0] ^ 8'ha5;
        end
        repeat (3) @(posedge clk0);
        rst_ni <= 1'b1;
        @(posedge clk0);
        write_burst(32'h0012_3420, 8, 1'b0, 1'b0, 1'b0);
        read_burst(32'h0012_3420, 8, 1'b0, 1'b0, 1'b1);
        write_burst(32'h00AB_C048, 6, 1'b1, 1'b1, 1'b0);
        read_burst(32'h00AB_C048, 6, 1'b1, 1'b1, 1'b1);
        read_burst(32'h0012_341C, 16, 1'b1, 1'b0, 1'b0);   // Wrapped burst type
        write_burst(32'h0000_0800, 1, 1'b0, 1'b0, 1'b1);    // Register write
        repeat (10) @(posedge clk0);
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hyper_phy.f
hw/hyper_pkg.sv
hw/hyper_ctrl_if.sv
hw/hyper_cmd_addr.sv
hw/hyper_trans_fsm.sv
hw/hyper_read_capture.sv
hw/hyper_phy_top.sv
test/hyper_mem_model.sv
test/tb_hyper_phy.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the HyperBus PHY testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f hyper_phy.f --top-module tb_hyper_phy -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
